// File: common/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [29:0] waddr_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [4:0]  reg_addr_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_PASS_B = 4'd8
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_LOAD = 2'd1,
        WB_PC4  = 2'd2
    } wb_src_e;

    // All-zero value is a bubble
    typedef struct packed {
        logic    rs1Used;
        logic    rs2Used;
        logic    aluBImm;
        alu_op_e aluOp;
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        logic    storeByte;
        logic    branch;
        logic    branchNe;
        logic    jump;
        wb_src_e wbSrc;
    } ctrl_t;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

// File: common/inst_bus_if.sv
`timescale 1ns/1ps

interface inst_bus_if;
    import cpu_pkg::*;

    waddr_t address;
    logic   read;
    word_t  readData;
    logic   waitReq;

    modport master (
        output address,
        output read,
        input  readData,
        input  waitReq
    );

    modport slave (
        input  address,
        input  read,
        output readData,
        output waitReq
    );

endinterface

// File: core/cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
    parameter cpu_pkg::word_t RESET_PC = 32'h0000_0000
)(
    input  logic              i_Clk,
    input  logic              i_rstN,

    inst_bus_if.master        ibus,

    output cpu_pkg::waddr_t   o_DBus_Address,
    output cpu_pkg::byte_en_t o_DBus_ByteEn,
    output logic              o_DBus_Read,
    output logic              o_DBus_Write,
    output cpu_pkg::word_t    o_DBus_WriteData,
    input  cpu_pkg::word_t    i_DBus_ReadData,
    input  logic              i_DBus_WaitRequest
);
    import cpu_pkg::*;

    word_t     pcF;
    logic      fetchEn;
    logic      fetchDone;

    word_t     instD;
    word_t     pcD;
    ctrl_t     ctrlD;
    word_t     immD;
    reg_addr_t rs1AddrD;
    reg_addr_t rs2AddrD;
    word_t     rs1DataD;
    word_t     rs2DataD;

    ctrl_t     ctrlE;
    word_t     pcE;
    word_t     immE;
    word_t     rs1DataE;
    word_t     rs2DataE;
    reg_addr_t rs1AddrE;
    reg_addr_t rs2AddrE;
    reg_addr_t rdAddrE;
    word_t     fwdAE;
    word_t     fwdBE;
    word_t     aluResultE;
    logic      equalE;
    logic      takeE;
    word_t     resultE;

    ctrl_t     ctrlM;
    word_t     resultM;
    word_t     storeDataM;
    reg_addr_t rdAddrM;

    ctrl_t     ctrlW;
    word_t     resultW;
    word_t     loadDataW;
    reg_addr_t rdAddrW;
    word_t     wbDataW;

    logic      memStall;
    logic      loadUse;
    logic      pipeEn;
    logic      redirect;
    logic      enD;
    logic      clrD;
    logic      clrE;

    // Hazard control
    assign memStall = (ctrlM.memRead || ctrlM.memWrite) && i_DBus_WaitRequest;
    assign loadUse  = ctrlE.memRead && (rdAddrE != '0) &&
                      ((ctrlD.rs1Used && rs1AddrD == rdAddrE) ||
                       (ctrlD.rs2Used && rs2AddrD == rdAddrE));
    assign pipeEn   = !memStall;
    assign redirect = pipeEn && takeE;
    assign enD      = pipeEn && !loadUse;
    assign clrD     = redirect || (enD && !fetchDone);
    assign clrE     = redirect || (pipeEn && loadUse);

    // Fetch
    assign ibus.address = pcF[31:2];
    assign ibus.read    = fetchEn;
    assign fetchDone    = ibus.read && !ibus.waitReq;

    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            fetchEn <= 1'b0;
            pcF     <= RESET_PC;
            instD   <= NOP_INSTR;
            ctrlE   <= '0;
            ctrlM   <= '0;
            ctrlW   <= '0;
        end else begin
            fetchEn <= 1'b1;
            if (redirect) begin
                pcF <= pcE + immE;
            end else if (enD && fetchDone) begin
                pcF <= pcF + 32'd4;
            end
            if (clrD) begin
                instD <= NOP_INSTR;
            end else if (enD) begin
                instD <= ibus.readData;
            end
            if (clrE) begin
                ctrlE <= '0;
            end else if (pipeEn) begin
                ctrlE <= ctrlD;
            end
            if (pipeEn) begin
                ctrlM <= ctrlE;
                ctrlW <= ctrlM;
            end
        end
    end

    always_ff @(posedge i_Clk) begin
        if (enD) begin
            pcD <= pcF;
        end
        if (pipeEn) begin
            pcE        <= pcD;
            immE       <= immD;
            rs1DataE   <= rs1DataD;
            rs2DataE   <= rs2DataD;
            rs1AddrE   <= rs1AddrD;
            rs2AddrE   <= rs2AddrD;
            rdAddrE    <= instD[11:7];
            resultM    <= resultE;
            storeDataM <= fwdBE;
            rdAddrM    <= rdAddrE;
            resultW    <= resultM;
            loadDataW  <= i_DBus_ReadData;
            rdAddrW    <= rdAddrM;
        end
    end

    // Decode
    assign rs1AddrD = instD[19:15];
    assign rs2AddrD = instD[24:20];

    inst_decoder instDecoder (
        .i_Inst (instD),
        .o_Ctrl (ctrlD),
        .o_Imm  (immD)
    );

    reg_file regFile (
        .i_Clk     (i_Clk),
        .i_rstN    (i_rstN),
        .i_Rs1Addr (rs1AddrD),
        .i_Rs2Addr (rs2AddrD),
        .o_Rs1Data (rs1DataD),
        .o_Rs2Data (rs2DataD),
        .i_WrEn    (ctrlW.regWrite),
        .i_WrAddr  (rdAddrW),
        .i_WrData  (wbDataW)
    );

    // Memory stage wins over write-back
    function automatic word_t forward(reg_addr_t addr, word_t regData);
        if (addr != '0 && ctrlM.regWrite && addr == rdAddrM) begin
            return resultM;
        end
        if (addr != '0 && ctrlW.regWrite && addr == rdAddrW) begin
            return wbDataW;
        end
        return regData;
    endfunction

    always_comb begin
        fwdAE = forward(rs1AddrE, rs1DataE);
        fwdBE = forward(rs2AddrE, rs2DataE);
    end

    exec_alu execAlu (
        .i_Op     (ctrlE.aluOp),
        .i_A      (fwdAE),
        .i_B      (ctrlE.aluBImm ? immE : fwdBE),
        .o_Result (aluResultE),
        .o_Equal  (equalE)
    );

    assign takeE   = ctrlE.jump || (ctrlE.branch && (equalE != ctrlE.branchNe));
    assign resultE = (ctrlE.wbSrc == WB_PC4) ? pcE + 32'd4 : aluResultE;

    // SB puts the byte on every lane
    assign o_DBus_Address   = resultM[31:2];
    assign o_DBus_Read      = ctrlM.memRead;
    assign o_DBus_Write     = ctrlM.memWrite;
    assign o_DBus_ByteEn    = ctrlM.storeByte ? byte_en_t'(4'b0001 << resultM[1:0]) : 4'b1111;
    assign o_DBus_WriteData = ctrlM.storeByte ? {4{storeDataM[7:0]}} : storeDataM;

    // Write-back
    assign wbDataW = (ctrlW.wbSrc == WB_LOAD) ? loadDataW : resultW;

endmodule

// File: core/exec_alu.sv
`timescale 1ns/1ps

module exec_alu (
    input  cpu_pkg::alu_op_e i_Op,
    input  cpu_pkg::word_t   i_A,
    input  cpu_pkg::word_t   i_B,
    output cpu_pkg::word_t   o_Result,
    output logic             o_Equal
);
    import cpu_pkg::*;

    logic [4:0] shamt;

    assign shamt   = i_B[4:0];
    assign o_Equal = (i_A == i_B);

    always_comb begin
        case (i_Op)
            ALU_ADD:    o_Result = i_A + i_B;
            ALU_SUB:    o_Result = i_A - i_B;
            ALU_AND:    o_Result = i_A & i_B;
            ALU_OR:     o_Result = i_A | i_B;
            ALU_XOR:    o_Result = i_A ^ i_B;
            ALU_SLT:    o_Result = {31'b0, $signed(i_A) < $signed(i_B)};
            ALU_SLL:    o_Result = i_A << shamt;
            ALU_SRL:    o_Result = i_A >> shamt;
            ALU_PASS_B: o_Result = i_B;
            default:    o_Result = '0;
        endcase
    end

endmodule

// File: core/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  cpu_pkg::word_t i_Inst,
    output cpu_pkg::ctrl_t o_Ctrl,
    output cpu_pkg::word_t o_Imm
);
    import cpu_pkg::*;

    logic [2:0] funct3;
    logic       funct7b5;

    assign funct3   = i_Inst[14:12];
    assign funct7b5 = i_Inst[30];

    always_comb begin
        o_Ctrl = '0;
        o_Imm  = {{20{i_Inst[31]}}, i_Inst[31:20]};
        case (opcode_e'(i_Inst[6:0]))
            OPC_LUI: begin
                o_Ctrl.aluBImm  = 1'b1;
                o_Ctrl.aluOp    = ALU_PASS_B;
                o_Ctrl.regWrite = 1'b1;
                o_Imm           = {i_Inst[31:12], 12'b0};
            end
            OPC_OP_IMM: begin
                o_Ctrl.rs1Used  = 1'b1;
                o_Ctrl.aluBImm  = 1'b1;
                o_Ctrl.regWrite = 1'b1;
                case (funct3)
                    3'b000:  o_Ctrl.aluOp = ALU_ADD;
                    3'b010:  o_Ctrl.aluOp = ALU_SLT;
                    3'b100:  o_Ctrl.aluOp = ALU_XOR;
                    3'b110:  o_Ctrl.aluOp = ALU_OR;
                    3'b111:  o_Ctrl.aluOp = ALU_AND;
                    default: o_Ctrl = '0;
                endcase
            end
            OPC_OP: begin
                o_Ctrl.rs1Used  = 1'b1;
                o_Ctrl.rs2Used  = 1'b1;
                o_Ctrl.regWrite = 1'b1;
                case (funct3)
                    3'b000:  o_Ctrl.aluOp = funct7b5 ? ALU_SUB : ALU_ADD;
                    3'b001:  o_Ctrl.aluOp = ALU_SLL;
                    3'b010:  o_Ctrl.aluOp = ALU_SLT;
                    3'b100:  o_Ctrl.aluOp = ALU_XOR;
                    3'b101:  o_Ctrl.aluOp = ALU_SRL;
                    3'b110:  o_Ctrl.aluOp = ALU_OR;
                    3'b111:  o_Ctrl.aluOp = ALU_AND;
                    default: o_Ctrl = '0;
                endcase
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin
                    o_Ctrl.rs1Used  = 1'b1;
                    o_Ctrl.aluBImm  = 1'b1;
                    o_Ctrl.regWrite = 1'b1;
                    o_Ctrl.memRead  = 1'b1;
                    o_Ctrl.wbSrc    = WB_LOAD;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010 || funct3 == 3'b000) begin
                    o_Ctrl.rs1Used   = 1'b1;
                    o_Ctrl.rs2Used   = 1'b1;
                    o_Ctrl.aluBImm   = 1'b1;
                    o_Ctrl.memWrite  = 1'b1;
                    o_Ctrl.storeByte = (funct3 == 3'b000);
                end
                o_Imm = {{20{i_Inst[31]}}, i_Inst[31:25], i_Inst[11:7]};
            end
            OPC_BRANCH: begin
                // Only BEQ and BNE
                if (funct3[2:1] == 2'b00) begin
                    o_Ctrl.rs1Used  = 1'b1;
                    o_Ctrl.rs2Used  = 1'b1;
                    o_Ctrl.aluOp    = ALU_SUB;
                    o_Ctrl.branch   = 1'b1;
                    o_Ctrl.branchNe = funct3[0];
                end
                o_Imm = {{19{i_Inst[31]}}, i_Inst[31], i_Inst[7], i_Inst[30:25],
                         i_Inst[11:8], 1'b0};
            end
            OPC_JAL: begin
                o_Ctrl.jump     = 1'b1;
                o_Ctrl.regWrite = 1'b1;
                o_Ctrl.wbSrc    = WB_PC4;
                o_Imm = {{11{i_Inst[31]}}, i_Inst[31], i_Inst[19:12], i_Inst[20],
                         i_Inst[30:21], 1'b0};
            end
            default: o_Ctrl = '0;
        endcase
    end

endmodule

// File: core/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                i_Clk,
    input  logic                i_rstN,
    input  cpu_pkg::reg_addr_t  i_Rs1Addr,
    input  cpu_pkg::reg_addr_t  i_Rs2Addr,
    output cpu_pkg::word_t      o_Rs1Data,
    output cpu_pkg::word_t      o_Rs2Data,
    input  logic                i_WrEn,
    input  cpu_pkg::reg_addr_t  i_WrAddr,
    input  cpu_pkg::word_t      i_WrData
);
    import cpu_pkg::*;

    // x0 has no storage
    word_t regs [31:1];

    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_WrEn && i_WrAddr != '0) begin
            regs[i_WrAddr] <= i_WrData;
        end
    end

    // Same-cycle write is visible to decode
    function automatic word_t readPort(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (i_WrEn && addr == i_WrAddr) begin
            return i_WrData;
        end
        return regs[addr];
    endfunction

    always_comb begin
        o_Rs1Data = readPort(i_Rs1Addr);
        o_Rs2Data = readPort(i_Rs2Addr);
    end

endmodule

// File: hw/cpu_system.sv
`timescale 1ns/1ps

module cpu_system #(
    parameter cpu_pkg::word_t RESET_PC        = 32'h0000_0000,
    parameter int unsigned    IMEM_DEPTH_LOG2 = 8,
    parameter int unsigned    IMEM_WAIT       = 1
)(
    input  logic              i_Clk,
    input  logic              i_rstN,

    // Program load, used during reset
    input  logic              i_LoadEn,
    input  cpu_pkg::waddr_t   i_LoadAddr,
    input  cpu_pkg::word_t    i_LoadData,

    output cpu_pkg::waddr_t   o_DBus_Address,
    output cpu_pkg::byte_en_t o_DBus_ByteEn,
    output logic              o_DBus_Read,
    output logic              o_DBus_Write,
    output cpu_pkg::word_t    o_DBus_WriteData,
    input  cpu_pkg::word_t    i_DBus_ReadData,
    input  logic              i_DBus_WaitRequest
);

    inst_bus_if iBus ();

    cpu_core #(
        .RESET_PC (RESET_PC)
    ) cpuCore (
        .i_Clk              (i_Clk),
        .i_rstN             (i_rstN),
        .ibus               (iBus.master),
        .o_DBus_Address     (o_DBus_Address),
        .o_DBus_ByteEn      (o_DBus_ByteEn),
        .o_DBus_Read        (o_DBus_Read),
        .o_DBus_Write       (o_DBus_Write),
        .o_DBus_WriteData   (o_DBus_WriteData),
        .i_DBus_ReadData    (i_DBus_ReadData),
        .i_DBus_WaitRequest (i_DBus_WaitRequest)
    );

    inst_memory #(
        .IMEM_DEPTH_LOG2 (IMEM_DEPTH_LOG2),
        .IMEM_WAIT       (IMEM_WAIT)
    ) instMemory (
        .i_Clk      (i_Clk),
        .i_rstN     (i_rstN),
        .bus        (iBus.slave),
        .i_LoadEn   (i_LoadEn),
        .i_LoadAddr (i_LoadAddr),
        .i_LoadData (i_LoadData)
    );

endmodule

// File: hw/inst_memory.sv
`timescale 1ns/1ps

module inst_memory #(
    parameter int unsigned IMEM_DEPTH_LOG2 = 8,
    parameter int unsigned IMEM_WAIT       = 1
)(
    input  logic            i_Clk,
    input  logic            i_rstN,
    inst_bus_if.slave       bus,
    input  logic            i_LoadEn,
    input  cpu_pkg::waddr_t i_LoadAddr,
    input  cpu_pkg::word_t  i_LoadData
);
    import cpu_pkg::*;

    localparam int unsigned DEPTH = 1 << IMEM_DEPTH_LOG2;
    localparam int unsigned CNT_W = $clog2(IMEM_WAIT + 2);

    word_t            mem [DEPTH];
    logic [CNT_W-1:0] waitCnt;
    logic [CNT_W-1:0] curCnt;
    waddr_t           lastAddr;
    logic             readInRange;
    logic             loadInRange;

    // New address starts a fresh wait
    assign curCnt      = (bus.address != lastAddr) ? '0 : waitCnt;
    assign bus.waitReq = bus.read && (curCnt < CNT_W'(IMEM_WAIT));

    assign readInRange  = (bus.address >> IMEM_DEPTH_LOG2) == '0;
    assign bus.readData = readInRange ? mem[bus.address[IMEM_DEPTH_LOG2-1:0]] : NOP_INSTR;

    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            waitCnt  <= '0;
            lastAddr <= '0;
        end else begin
            lastAddr <= bus.address;
            // Restart after every completed read
            if (bus.read && bus.waitReq) begin
                waitCnt <= curCnt + 1'b1;
            end else begin
                waitCnt <= '0;
            end
        end
    end

    assign loadInRange = (i_LoadAddr >> IMEM_DEPTH_LOG2) == '0;

    always_ff @(posedge i_Clk) begin
        if (i_LoadEn && loadInRange) begin
            mem[i_LoadAddr[IMEM_DEPTH_LOG2-1:0]] <= i_LoadData;
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -j 0 --top-module tb_cpu_system -f src.f \
    --Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST PASS" "$LOG_FILE"; then
    exit 0
fi
echo "Pass line not found in $LOG_FILE"
exit 1

// File: src.f
common/cpu_pkg.sv
common/inst_bus_if.sv
core/exec_alu.sv
core/reg_file.sv
core/inst_decoder.sv
core/cpu_core.sv
hw/inst_memory.sv
hw/cpu_system.sv
tb/tb_cpu_system.sv

// File: tb/tb_cpu_system.sv
`timescale 1ns/1ps

module tb_cpu_system;
    import cpu_pkg::*;

    localparam int     TIMEOUT_CYCLES = 2000;
    localparam waddr_t END_ADDR       = 30'h0FF;

    typedef struct packed {
        waddr_t   addr;
        byte_en_t byteEn;
        word_t    data;
    } write_t;

    logic     i_Clk;
    logic     i_rstN;
    logic     i_LoadEn;
    waddr_t   i_LoadAddr;
    word_t    i_LoadData;
    waddr_t   o_DBus_Address;
    byte_en_t o_DBus_ByteEn;
    logic     o_DBus_Read;
    logic     o_DBus_Write;
    word_t    o_DBus_WriteData;
    word_t    i_DBus_ReadData = '0;
    logic     i_DBus_WaitRequest = 1'b0;

    word_t       dmem [waddr_t];
    word_t       prog [$];
    write_t      expected [$];
    write_t      observed [$];
    int          errors;
    logic        randomWaits;
    logic [31:0] rngState = 32'h830eeef0;
    logic        inAccess = 1'b0;
    int          waitLeft = 0;
    logic        endSeen = 1'b0;
    word_t       merged;

    cpu_system cpu_system_inst (
        .i_Clk              (i_Clk),
        .i_rstN             (i_rstN),
        .i_LoadEn           (i_LoadEn),
        .i_LoadAddr         (i_LoadAddr),
        .i_LoadData         (i_LoadData),
        .o_DBus_Address     (o_DBus_Address),
        .o_DBus_ByteEn      (o_DBus_ByteEn),
        .o_DBus_Read        (o_DBus_Read),
        .o_DBus_Write       (o_DBus_Write),
        .o_DBus_WriteData   (o_DBus_WriteData),
        .i_DBus_ReadData    (i_DBus_ReadData),
        .i_DBus_WaitRequest (i_DBus_WaitRequest)
    );

    always #2 i_Clk = ~i_Clk;

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // Data memory, one access at a time
    always @(negedge i_Clk) begin
        if (!i_rstN) begin
            inAccess           = 1'b0;
            endSeen            = 1'b0;
            i_DBus_WaitRequest = 1'b0;
            observed.delete();
            dmem.delete();
        end else if (o_DBus_Read || o_DBus_Write) begin
            if (!inAccess) begin
                inAccess = 1'b1;
                waitLeft = randomWaits ? int'(nextRandom() % 4) : 0;
            end
            if (waitLeft > 0) begin
                waitLeft           = waitLeft - 1;
                i_DBus_WaitRequest = 1'b1;
            end else begin
                // Completes at the next rising edge
                inAccess           = 1'b0;
                i_DBus_WaitRequest = 1'b0;
                merged = dmem.exists(o_DBus_Address) ? dmem[o_DBus_Address] : '0;
                if (o_DBus_Read) begin
                    i_DBus_ReadData = merged;
                end
                if (o_DBus_Write) begin
                    for (int b = 0; b < 4; b++) begin
                        if (o_DBus_ByteEn[b]) begin
                            merged[8*b +: 8] = o_DBus_WriteData[8*b +: 8];
                        end
                    end
                    dmem[o_DBus_Address] = merged;
                    observed.push_back({o_DBus_Address, o_DBus_ByteEn, o_DBus_WriteData});
                    if (o_DBus_Address == END_ADDR) begin
                        endSeen = 1'b1;
                    end
                end
            end
        end else begin
            i_DBus_WaitRequest = 1'b0;
        end
    end

    // RV32I encodings
    function automatic word_t iType(opcode_e opc, logic [2:0] f3, reg_addr_t rd,
                                    reg_addr_t rs1, word_t imm);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic word_t rType(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t sType(logic [2:0] f3, reg_addr_t rs2, reg_addr_t rs1, word_t imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t bType(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2, word_t imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t uType(reg_addr_t rd, logic [19:0] upper);
        return {upper, rd, OPC_LUI};
    endfunction

    function automatic word_t jType(reg_addr_t rd, word_t imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic emit(input word_t instr);
        prog.push_back(instr);
    endtask

    task automatic expectWrite(input word_t byteAddr, input byte_en_t be, input word_t data);
        expected.push_back({byteAddr[31:2], be, data});
    endtask

    task automatic newProgram();
        prog.delete();
        expected.delete();
        randomWaits = 1'b0;
    endtask

    // Marker store, then spin in place
    task automatic finishProgram();
        emit(sType(3'b010, 5'd0, 5'd0, 32'h3FC));
        expectWrite(32'h3FC, 4'b1111, 32'h0);
        emit(jType(5'd0, 32'h0));
        emit(NOP_INSTR);
        emit(NOP_INSTR);
    endtask

    task automatic checkWord(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic checkAddr(input string name, input waddr_t exp, input waddr_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic checkByteEn(input string name, input byte_en_t exp, input byte_en_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    // Bus must stay idle while the program is written
    task automatic resetAndLoad();
        int n;
        n = (prog.size() > 16) ? prog.size() : 16;
        @(negedge i_Clk);
        i_rstN = 1'b0;
        for (int i = 0; i < n; i++) begin
            @(negedge i_Clk);
            i_LoadEn   = (i < prog.size());
            i_LoadAddr = waddr_t'(i);
            i_LoadData = (i < prog.size()) ? prog[i] : NOP_INSTR;
            checkBit("o_DBus_Read", 1'b0, o_DBus_Read);
            checkBit("o_DBus_Write", 1'b0, o_DBus_Write);
        end
        @(negedge i_Clk);
        i_LoadEn = 1'b0;
        i_rstN   = 1'b1;
    endtask

    task automatic waitForEnd(input string testName);
        int cycles;
        cycles = 0;
        while (!endSeen && cycles < TIMEOUT_CYCLES) begin
            @(posedge i_Clk);
            cycles++;
        end
        if (!endSeen) begin
            errors++;
            $display("%s: no store to 0x3FC within %0d cycles", testName, TIMEOUT_CYCLES);
        end
    endtask

    task automatic compareWrites(input string testName);
        int n;
        n = (observed.size() < expected.size()) ? observed.size() : expected.size();
        if (observed.size() != expected.size()) begin
            errors++;
            $display("%s: expected %0d completed writes, saw %0d",
                     testName, expected.size(), observed.size());
        end
        for (int i = 0; i < n; i++) begin
            checkAddr("o_DBus_Address", expected[i].addr, observed[i].addr);
            checkByteEn("o_DBus_ByteEn", expected[i].byteEn, observed[i].byteEn);
            checkWord("o_DBus_WriteData", expected[i].data, observed[i].data);
        end
    endtask

    task automatic runProgram(input string testName);
        resetAndLoad();
        waitForEnd(testName);
        compareWrites(testName);
    endtask

    // Chain where each result feeds the next
    task automatic buildArith();
        word_t v [1:14];
        newProgram();
        v[1]  = 32'h1234_5678;
        v[2]  = 32'hFFFF_FFFB;
        v[3]  = v[1] + v[2];
        v[4]  = v[3] - v[1];
        v[5]  = v[4] ^ 32'h0F0;
        v[6]  = v[5] & v[1];
        v[7]  = v[6] | v[2];
        v[8]  = ($signed(v[2]) < $signed(v[1])) ? 32'd1 : 32'd0;
        v[9]  = ($signed(v[1]) < $signed(32'hFFFF_FFFF)) ? 32'd1 : 32'd0;
        v[10] = 32'd4;
        v[11] = v[1] << 4;
        v[12] = v[2] >> 4;
        v[13] = v[12] | 32'h7FF;
        v[14] = v[13] & 32'h555;
        emit(uType(5'd1, 20'h12345));
        emit(iType(OPC_OP_IMM, 3'b000, 5'd1, 5'd1, 32'h678));
        emit(sType(3'b010, 5'd1, 5'd0, 32'h104));
        emit(iType(OPC_OP_IMM, 3'b000, 5'd2, 5'd0, 32'hFFFF_FFFB));
        emit(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        emit(sType(3'b010, 5'd3, 5'd0, 32'h10C));
        emit(rType(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
        emit(iType(OPC_OP_IMM, 3'b100, 5'd5, 5'd4, 32'h0F0));
        emit(rType(7'h00, 5'd1, 5'd5, 3'b111, 5'd6));
        emit(rType(7'h00, 5'd2, 5'd6, 3'b110, 5'd7));
        emit(rType(7'h00, 5'd1, 5'd2, 3'b010, 5'd8));
        emit(iType(OPC_OP_IMM, 3'b010, 5'd9, 5'd1, 32'hFFFF_FFFF));
        emit(iType(OPC_OP_IMM, 3'b000, 5'd10, 5'd0, 32'h4));
        emit(rType(7'h00, 5'd10, 5'd1, 3'b001, 5'd11));
        emit(rType(7'h00, 5'd10, 5'd2, 3'b101, 5'd12));
        emit(iType(OPC_OP_IMM, 3'b110, 5'd13, 5'd12, 32'h7FF));
        emit(iType(OPC_OP_IMM, 3'b111, 5'd14, 5'd13, 32'h555));
        expectWrite(32'h104, 4'b1111, v[1]);
        expectWrite(32'h10C, 4'b1111, v[3]);
        for (int r = 4; r <= 14; r++) begin
            emit(sType(3'b010, reg_addr_t'(r), 5'd0, 32'h100 + 4 * r));
            expectWrite(32'h100 + 4 * r, 4'b1111, v[r]);
        end
        finishProgram();
    endtask

    task automatic dependentArith();
        buildArith();
        runProgram("dependentArith");
    endtask

    task automatic loadUse();
        word_t base;
        newProgram();
        base = 32'h0ABC_D123;
        emit(uType(5'd1, 20'h0ABCD));
        emit(iType(OPC_OP_IMM, 3'b000, 5'd1, 5'd1, 32'h123));
        emit(sType(3'b010, 5'd1, 5'd0, 32'h200));
        emit(iType(OPC_LOAD, 3'b010, 5'd2, 5'd0, 32'h200));
        emit(iType(OPC_OP_IMM, 3'b000, 5'd3, 5'd2, 32'h55));
        emit(sType(3'b010, 5'd3, 5'd0, 32'h204));
        emit(iType(OPC_LOAD, 3'b010, 5'd4, 5'd0, 32'h204));
        emit(rType(7'h00, 5'd4, 5'd1, 3'b000, 5'd5));
        emit(sType(3'b010, 5'd5, 5'd0, 32'h208));
        // Loaded value goes straight to store data
        emit(iType(OPC_LOAD, 3'b010, 5'd6, 5'd0, 32'h208));
        emit(sType(3'b010, 5'd6, 5'd0, 32'h20C));
        expectWrite(32'h200, 4'b1111, base);
        expectWrite(32'h204, 4'b1111, base + 32'h55);
        expectWrite(32'h208, 4'b1111, base + base + 32'h55);
        expectWrite(32'h20C, 4'b1111, base + base + 32'h55);
        finishProgram();
        runProgram("loadUse");
    endtask

    task automatic controlFlow();
        word_t sum;
        word_t jalPc;
        newProgram();
        sum = 32'd0;
        for (int k = 5; k > 0; k--) begin
            sum = sum + 32'(k);
        end
        emit(iType(OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 32'd5));
        emit(iType(OPC_OP_IMM, 3'b000, 5'd2, 5'd0, 32'd0));
        emit(rType(7'h00, 5'd1, 5'd2, 3'b000, 5'd2));
        emit(iType(OPC_OP_IMM, 3'b000, 5'd1, 5'd1, 32'hFFFF_FFFF));
        emit(bType(3'b001, 5'd1, 5'd0, -8));
        emit(sType(3'b010, 5'd2, 5'd0, 32'h300));
        jalPc = 32'(prog.size() * 4);
        emit(jType(5'd5, 32'd8));
        emit(sType(3'b010, 5'd2, 5'd0, 32'h304));
        emit(sType(3'b010, 5'd5, 5'd0, 32'h308));
        // Taken BEQ skips two stores
        emit(bType(3'b000, 5'd0, 5'd0, 32'd12));
        emit(sType(3'b010, 5'd1, 5'd0, 32'h30C));
        emit(sType(3'b010, 5'd1, 5'd0, 32'h310));
        emit(sType(3'b010, 5'd2, 5'd0, 32'h314));
        emit(bType(3'b001, 5'd0, 5'd0, 32'd8));
        emit(sType(3'b010, 5'd2, 5'd0, 32'h318));
        expectWrite(32'h300, 4'b1111, sum);
        expectWrite(32'h308, 4'b1111, jalPc + 32'd4);
        expectWrite(32'h314, 4'b1111, sum);
        expectWrite(32'h318, 4'b1111, sum);
        finishProgram();
        runProgram("controlFlow");
    endtask

    task automatic byteStores();
        logic [7:0] bv;
        word_t      word;
        newProgram();
        word = 32'h1122_3344;
        emit(uType(5'd1, 20'h11223));
        emit(iType(OPC_OP_IMM, 3'b000, 5'd1, 5'd1, 32'h344));
        emit(sType(3'b010, 5'd1, 5'd0, 32'h280));
        emit(iType(OPC_OP_IMM, 3'b000, 5'd2, 5'd0, 32'hA5));
        expectWrite(32'h280, 4'b1111, word);
        for (int b = 0; b < 4; b++) begin
            bv = 8'hA5 + 8'(b);
            emit(sType(3'b000, 5'd2, 5'd0, 32'h280 + b));
            emit(iType(OPC_OP_IMM, 3'b000, 5'd2, 5'd2, 32'd1));
            expectWrite(32'h280 + b, byte_en_t'(4'b0001 << b), {4{bv}});
            word[8*b +: 8] = bv;
        end
        emit(iType(OPC_LOAD, 3'b010, 5'd3, 5'd0, 32'h280));
        emit(sType(3'b010, 5'd3, 5'd0, 32'h284));
        expectWrite(32'h284, 4'b1111, word);
        finishProgram();
        runProgram("byteStores");
        checkWord("dmem[0x280]", word, dmem[30'h0A0]);
    endtask

    task automatic waitStates();
        buildArith();
        randomWaits = 1'b1;
        runProgram("waitStates");
    endtask

    // First fetch takes IMEM_WAIT+1 cycles after fetch starts
    task automatic resetOutputs();
        newProgram();
        finishProgram();
        resetAndLoad();
        for (int c = 0; c < 3; c++) begin
            @(negedge i_Clk);
            checkBit("o_DBus_Read", 1'b0, o_DBus_Read);
            checkBit("o_DBus_Write", 1'b0, o_DBus_Write);
        end
        waitForEnd("resetOutputs");
        compareWrites("resetOutputs");
    endtask

    initial begin
        i_Clk       = 1'b0;
        i_rstN      = 1'b0;
        i_LoadEn    = 1'b0;
        i_LoadAddr  = '0;
        i_LoadData  = '0;
        errors      = 0;
        randomWaits = 1'b0;
        dependentArith();
        loadUse();
        controlFlow();
        byteStores();
        waitStates();
        resetOutputs();
        $display("Checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
